// File: design/scmDotPkg.sv
package scmDotPkg;

    // ----------------------------------------------------------------------
    // Geometry of the two scratch memories and the datapath
    // ----------------------------------------------------------------------

    // Address bits per memory, 32 words
    localparam int AddrWidth = 5;

    // One weight or pixel word
    localparam int DataWidth = 16;

    // Accumulator width, leaves headroom over the 32-bit products
    localparam int AccWidth = 40;

    // Word address into either memory
    typedef logic [AddrWidth-1:0] addrT;

    // Weight and pixel values are two's complement
    typedef logic signed [DataWidth-1:0] dataT;

    // Dot-product result
    typedef logic signed [AccWidth-1:0] accT;

    // Run length, one bit wider than an address so 32 fits; zero is a no-op
    typedef logic [AddrWidth:0] lenT;

    // Sequencer states
    typedef enum logic [1:0] {
        SeqIdle,
        SeqRun,
        SeqDrain
    } seqStateT;

endpackage

// File: design/clockGateCell.sv
`timescale 1ns/1ps

module clockGateCell
(
    input  logic clk,
    input  logic en_i,
    input  logic testEn_i,
    output logic gclk_o
);

    // Enable as seen by the AND gate
    logic enLatched;

    // ----------------------------------------------------------------------
    // Low-phase latch
    // ----------------------------------------------------------------------

    // Transparent while clk is low so the enable settles before the rising edge
    // Test enable forces the clock through for scan
    always_latch
    begin
        if (!clk)
            enLatched <= en_i | testEn_i;
    end

    // Enable is stable during the high phase, no glitch on the gated clock
    assign gclk_o = clk & enLatched;

endmodule

// File: design/registerFile1r1w.sv
`timescale 1ns/1ps

module registerFile1r1w
#(
    parameter int AddrWidth = scmDotPkg::AddrWidth,
    parameter int DataWidth = scmDotPkg::DataWidth
)
(
    input  logic            clk,

    // Scan override for all clock gates
    input  logic            testEn_i,

    // Read port
    input  logic            readEn_i,
    input  scmDotPkg::addrT readAddr_i,
    output scmDotPkg::dataT readData_o,

    // Write port
    input  logic            writeEn_i,
    input  scmDotPkg::addrT writeAddr_i,
    input  scmDotPkg::dataT writeData_i
);

    localparam int NumWords = 2**AddrWidth;

    // Registered read address, drives the output mux
    logic [AddrWidth-1:0] readAddrQ;

    // Latch array, one entry per word
    logic [DataWidth-1:0] memWords [NumWords];

    // Write path
    logic [NumWords-1:0]  writeOneHot;
    logic [NumWords-1:0]  wordClk;
    logic [DataWidth-1:0] writeDataQ;

    // Clock that only toggles in cycles with a write
    logic                 writeClk;

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------

    // Address captured only on a read, so readData_o holds between reads
    always_ff @(posedge clk)
    begin
        if (readEn_i)
            readAddrQ <= readAddr_i;
    end

    // Mux straight out of the latches, one cycle after readEn_i
    assign readData_o = memWords[readAddrQ];

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------

    // Global gate, keeps the per-word gates quiet in idle cycles
    clockGateCell writeGate
    (
        .clk      (clk),
        .en_i     (writeEn_i),
        .testEn_i (testEn_i),
        .gclk_o   (writeClk)
    );

    // One-hot decode of the write address
    always_comb
    begin
        writeOneHot = '0;
        if (writeEn_i)
            writeOneHot[writeAddr_i] = 1'b1;
    end

    // Data sampled at the write edge
    // the word latch then copies it during the high phase
    always_ff @(posedge clk)
    begin
        if (writeEn_i)
            writeDataQ <= writeData_i;
    end

    // Per-word gate and storage latch
    for (genvar w = 0; w < NumWords; w++)
    begin : gWord
        // Only the addressed word sees a clock pulse
        clockGateCell wordGate
        (
            .clk      (writeClk),
            .en_i     (writeOneHot[w]),
            .testEn_i (testEn_i),
            .gclk_o   (wordClk[w])
        );

        // Transparent while the gated clock is high
        always_latch
        begin
            if (wordClk[w])
                memWords[w] <= writeDataQ;
        end
    end

endmodule

// File: design/dotSequencer.sv
`timescale 1ns/1ps

module dotSequencer
#(
    parameter int AddrWidth = scmDotPkg::AddrWidth
)
(
    input  logic            clk,
    input  logic            rst_i,

    // Host command
    input  logic            start_i,
    input  scmDotPkg::lenT  len_i,

    // Read request to both memories
    output logic            readEn_o,
    output scmDotPkg::addrT readAddr_o,

    // Tags aligned with the memory read data
    output logic            macValid_o,
    output logic            macFirst_o,
    output logic            macLast_o,

    // Status
    output logic            busy_o,
    output logic            done_o
);

    import scmDotPkg::*;

    seqStateT             state;

    // Address of the final word of the run
    logic [AddrWidth-1:0] lastAddr;

    // Last product has been taken by the accumulator
    logic                 lastAbsorbed;

    // Start qualified by idle state and a nonzero length
    logic                 startOk;

    assign startOk = start_i && (len_i != '0) && (state == SeqIdle);

    // Busy covers run and drain, drops with done
    assign busy_o = (state != SeqIdle);

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------

    // Length only matters while a run is in progress
    always_ff @(posedge clk)
    begin
        if (startOk)
            lastAddr <= AddrWidth'(len_i - 1'b1);
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state      <= SeqIdle;
            readEn_o   <= 1'b0;
            readAddr_o <= '0;
            done_o     <= 1'b0;
        end
        else
        begin
            // Done is a single-cycle pulse
            done_o <= 1'b0;
            case (state)
                SeqIdle:
                begin
                    // First read goes out right after the start edge
                    if (startOk)
                    begin
                        state      <= SeqRun;
                        readEn_o   <= 1'b1;
                        readAddr_o <= '0;
                    end
                end
                SeqRun:
                begin
                    // One address per cycle until the last word
                    if (readAddr_o == lastAddr)
                    begin
                        readEn_o <= 1'b0;
                        state    <= SeqDrain;
                    end
                    else
                        readAddr_o <= readAddr_o + 1'b1;
                end
                SeqDrain:
                begin
                    // Result register is final, report it
                    if (lastAbsorbed)
                    begin
                        done_o <= 1'b1;
                        state  <= SeqIdle;
                    end
                end
                default:
                    state <= SeqIdle;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Tag pipeline, one stage to match the memory read latency
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            macValid_o   <= 1'b0;
            macFirst_o   <= 1'b0;
            macLast_o    <= 1'b0;
            lastAbsorbed <= 1'b0;
        end
        else
        begin
            macValid_o   <= readEn_o;
            macFirst_o   <= readEn_o && (readAddr_o == '0);
            macLast_o    <= readEn_o && (readAddr_o == lastAddr);
            // Accumulator updates on the edge that sees macLast_o
            lastAbsorbed <= macLast_o;
        end
    end

endmodule

// File: design/macAccumulator.sv
`timescale 1ns/1ps

module macAccumulator
(
    input  logic            clk,
    input  logic            rst_i,

    // Operands straight from the two memories
    input  scmDotPkg::dataT weight_i,
    input  scmDotPkg::dataT pixel_i,

    // Tags from the sequencer
    input  logic            valid_i,
    input  logic            first_i,

    output scmDotPkg::accT  result_o
);

    import scmDotPkg::*;

    // Full-precision product of two signed words
    logic signed [2*DataWidth-1:0] product;

    // Product widened to the accumulator
    accT productExt;

    // Running sum
    accT accQ;

    // ----------------------------------------------------------------------
    // Multiply
    // ----------------------------------------------------------------------

    // Both operands signed, so this is a signed multiply
    assign product = weight_i * pixel_i;

    // Size cast keeps the sign of the product
    assign productExt = accT'(product);

    // ----------------------------------------------------------------------
    // Accumulate
    // ----------------------------------------------------------------------

    // First tag restarts the sum, no carry-over between runs
    // Outside valid cycles the register just holds
    always_ff @(posedge clk)
    begin
        if (rst_i)
            accQ <= '0;
        else if (valid_i)
        begin
            if (first_i)
                accQ <= productExt;
            else
                accQ <= accQ + productExt;
        end
    end

    // Result stays put until the next run loads a new first product
    assign result_o = accQ;

endmodule

// File: design/scmDotTop.sv
`timescale 1ns/1ps

module scmDotTop
#(
    parameter int AddrWidth = scmDotPkg::AddrWidth,
    parameter int DataWidth = scmDotPkg::DataWidth
)
(
    input  logic            clk,
    input  logic            rst_i,

    // Scan override for the memory clock gates
    input  logic            testEn_i,

    // Weight memory write port
    input  logic            weightWe_i,
    input  scmDotPkg::addrT weightAddr_i,
    input  scmDotPkg::dataT weightData_i,

    // Pixel memory write port
    input  logic            pixelWe_i,
    input  scmDotPkg::addrT pixelAddr_i,
    input  scmDotPkg::dataT pixelData_i,

    // Run command
    input  logic            start_i,
    input  scmDotPkg::lenT  len_i,

    // Status and result
    output logic            busy_o,
    output logic            done_o,
    output scmDotPkg::accT  result_o
);

    import scmDotPkg::*;

    // Shared read request, both memories read the same address
    logic readEn;
    addrT readAddr;

    // Memory outputs, valid one cycle after readEn
    dataT weightData;
    dataT pixelData;

    // Tags aligned with weightData and pixelData
    logic macValid;
    logic macFirst;

    // ----------------------------------------------------------------------
    // Memories
    // ----------------------------------------------------------------------

    registerFile1r1w
    #(
        .AddrWidth (AddrWidth),
        .DataWidth (DataWidth)
    )
    weightMem
    (
        .clk         (clk),
        .testEn_i    (testEn_i),
        .readEn_i    (readEn),
        .readAddr_i  (readAddr),
        .readData_o  (weightData),
        .writeEn_i   (weightWe_i),
        .writeAddr_i (weightAddr_i),
        .writeData_i (weightData_i)
    );

    registerFile1r1w
    #(
        .AddrWidth (AddrWidth),
        .DataWidth (DataWidth)
    )
    pixelMem
    (
        .clk         (clk),
        .testEn_i    (testEn_i),
        .readEn_i    (readEn),
        .readAddr_i  (readAddr),
        .readData_o  (pixelData),
        .writeEn_i   (pixelWe_i),
        .writeAddr_i (pixelAddr_i),
        .writeData_i (pixelData_i)
    );

    // ----------------------------------------------------------------------
    // Control and datapath
    // ----------------------------------------------------------------------

    // Last tag stays inside the sequencer, it times the done pulse
    dotSequencer
    #(
        .AddrWidth (AddrWidth)
    )
    sequencer
    (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .len_i      (len_i),
        .readEn_o   (readEn),
        .readAddr_o (readAddr),
        .macValid_o (macValid),
        .macFirst_o (macFirst),
        .macLast_o  (),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    macAccumulator mac
    (
        .clk      (clk),
        .rst_i    (rst_i),
        .weight_i (weightData),
        .pixel_i  (pixelData),
        .valid_i  (macValid),
        .first_i  (macFirst),
        .result_o (result_o)
    );

endmodule

// File: verif/scmDot_assertions.sv
`timescale 1ns/1ps

module scmDotAssertions
(
    input logic clk,
    input logic rst_i,
    input logic readEn_i,
    input logic busy_i,
    input logic done_i
);

    // ----------------------------------------------------------------------
    // Done pulse and run status
    // ----------------------------------------------------------------------

    // One done per run
    property doneSinglePulse;
        @(posedge clk) disable iff (rst_i) done_i |=> !done_i;
    endproperty

    // Done only closes a run that was busy
    property doneAfterBusy;
        @(posedge clk) disable iff (rst_i) done_i |-> $past(busy_i);
    endproperty

    // No memory reads outside a run
    property noReadWhenIdle;
        @(posedge clk) disable iff (rst_i) !busy_i |-> !readEn_i;
    endproperty

    doneSinglePulseA: assert property (doneSinglePulse)
        else $error("done_o stayed high for two cycles");

    doneAfterBusyA: assert property (doneAfterBusy)
        else $error("done_o without busy_o in the cycle before");

    noReadWhenIdleA: assert property (noReadWhenIdle)
        else $error("Memory read issued while the engine is idle");

endmodule

bind scmDotTop scmDotAssertions protocolChecks
(
    .clk      (clk),
    .rst_i    (rst_i),
    .readEn_i (readEn),
    .busy_i   (busy_o),
    .done_i   (done_o)
);

// File: verif/scmDotTb.sv
`timescale 1ns/1ps

module scmDotTb;

    import scmDotPkg::*;

    // Row kinds of the stimulus table
    typedef enum logic [1:0] {
        OpWriteWeight,
        OpWritePixel,
        OpStart,
        OpStartBusy
    } opT;

    typedef struct {
        opT   op;
        addrT addr;
        dataT data;
        lenT  len;
        accT  expected;
    } rowT;

    localparam int   ResetCycles  = 3;
    localparam int   CyclesPerRow = 40;
    localparam int   NumWords     = 2**AddrWidth;
    // Length carried by the start that lands mid-run
    localparam lenT  IgnoredLen   = lenT'(4);
    localparam dataT MinData      = dataT'(-32768);
    localparam dataT MaxData      = dataT'(32767);

    logic clk;
    logic rst_i;
    logic testEn_i;
    logic weightWe_i;
    addrT weightAddr_i;
    dataT weightData_i;
    logic pixelWe_i;
    addrT pixelAddr_i;
    dataT pixelData_i;
    logic start_i;
    lenT  len_i;
    logic busy_o;
    logic done_o;
    accT  result_o;

    rowT  stimRows[$];
    // Shadow copies of the two memories
    dataT shadowWeight[NumWords];
    dataT shadowPixel[NumWords];
    accT  lastExpected;
    int   seed;
    int   cycleCount = 0;
    int   timeoutLimit;
    bit   failReported = 1'b0;
    bit   passReported = 1'b0;

    scmDotTop #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) scmDotTop_i
    (
        .clk          (clk),
        .rst_i        (rst_i),
        .testEn_i     (testEn_i),
        .weightWe_i   (weightWe_i),
        .weightAddr_i (weightAddr_i),
        .weightData_i (weightData_i),
        .pixelWe_i    (pixelWe_i),
        .pixelAddr_i  (pixelAddr_i),
        .pixelData_i  (pixelData_i),
        .start_i      (start_i),
        .len_i        (len_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // Run limit from the table length
    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutLimit)
        begin
            failReported = 1'b1;
            $display("Timeout: the run did not end within %0d cycles", timeoutLimit);
            $display("Testbench failed");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    // Run ended by an assertion
    final
    begin
        if (!passReported && !failReported)
            $display("Testbench failed");
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    task automatic stopOnFailure();
        failReported = 1'b1;
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkAcc(input string name, input accT actual, input accT expected);
        if (actual !== expected)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            stopOnFailure();
        end
    endtask

    // ----------------------------------------------------------------------
    // Table and reference model
    // ----------------------------------------------------------------------

    // Signed dot product over words 0 to len-1 of the shadow memories
    function automatic accT dotModel(input lenT len);
        longint sum;
        sum = 0;
        for (int i = 0; i < int'(len); i++)
            sum += longint'(shadowWeight[i]) * longint'(shadowPixel[i]);
        return accT'(sum);
    endfunction

    task automatic addWrite(input opT op, input addrT addr, input dataT data);
        rowT row;
        row.op       = op;
        row.addr     = addr;
        row.data     = data;
        row.len      = '0;
        row.expected = lastExpected;
        if (op == OpWriteWeight)
            shadowWeight[addr] = data;
        else
            shadowPixel[addr] = data;
        stimRows.push_back(row);
    endtask

    // Zero length keeps the previous result
    task automatic addStart(input opT op, input lenT len);
        rowT row;
        if (len != '0)
            lastExpected = dotModel(len);
        row.op       = op;
        row.addr     = '0;
        row.data     = '0;
        row.len      = len;
        row.expected = lastExpected;
        stimRows.push_back(row);
    endtask

    task automatic fillTable();
        int value;
        lastExpected = '0;
        // One-word run
        addWrite(OpWriteWeight, addrT'(0), dataT'(-1234));
        addWrite(OpWritePixel, addrT'(0), dataT'(567));
        addStart(OpStart, lenT'(1));
        // Full random fill, long and short runs
        for (int i = 0; i < NumWords; i++)
        begin
            value = $random(seed);
            addWrite(OpWriteWeight, addrT'(i), dataT'(value));
            value = $random(seed);
            addWrite(OpWritePixel, addrT'(i), dataT'(value));
        end
        addStart(OpStart, lenT'(32));
        addStart(OpStart, lenT'(7));
        // Extremes, largest product is 2^30
        for (int i = 0; i < 4; i++)
            addWrite(OpWriteWeight, addrT'(i), MinData);
        addWrite(OpWritePixel, addrT'(0), MinData);
        addWrite(OpWritePixel, addrT'(1), MinData);
        addWrite(OpWriteWeight, addrT'(31), MaxData);
        addWrite(OpWritePixel, addrT'(31), MinData);
        addStart(OpStart, lenT'(32));
        addStart(OpStart, lenT'(4));
        // Rejected starts
        addStart(OpStartBusy, lenT'(10));
        addStart(OpStart, lenT'(0));
        // Back-to-back runs
        addStart(OpStart, lenT'(32));
        addStart(OpStart, lenT'(1));
        addStart(OpStart, lenT'(5));
        addStart(OpStart, lenT'(32));
    endtask

    // ----------------------------------------------------------------------
    // Drivers
    // ----------------------------------------------------------------------

    // Drive slot, 2 ns after the rising edge
    task automatic advanceCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic writeWord(input rowT row);
        if (row.op == OpWriteWeight)
        begin
            weightWe_i   = 1'b1;
            weightAddr_i = row.addr;
            weightData_i = row.data;
        end
        else
        begin
            pixelWe_i   = 1'b1;
            pixelAddr_i = row.addr;
            pixelData_i = row.data;
        end
        advanceCycle();
        weightWe_i = 1'b0;
        pixelWe_i  = 1'b0;
        checkBit("busy_o", busy_o, 1'b0);
    endtask

    task automatic runDot(input rowT row);
        int edges;
        edges   = 0;
        start_i = 1'b1;
        len_i   = row.len;
        // Edge 0 samples the start
        advanceCycle();
        start_i = 1'b0;
        if (row.len == '0)
        begin
            for (int i = 0; i < 4; i++)
            begin
                checkBit("busy_o", busy_o, 1'b0);
                checkBit("done_o", done_o, 1'b0);
                advanceCycle();
            end
            checkAcc("result_o", result_o, row.expected);
        end
        else
        begin
            while (done_o !== 1'b1)
            begin
                checkBit("busy_o", busy_o, 1'b1);
                // Second start arrives mid-run
                if (row.op == OpStartBusy && edges == 1)
                begin
                    start_i = 1'b1;
                    len_i   = IgnoredLen;
                end
                advanceCycle();
                start_i = 1'b0;
                edges++;
            end
            if (edges != int'(row.len) + 2)
            begin
                $display("done_o came %0d edges after start, expected %0d",
                         edges, int'(row.len) + 2);
                stopOnFailure();
            end
            checkBit("busy_o", busy_o, 1'b0);
            checkAcc("result_o", result_o, row.expected);
            // The dropped start must not launch a run of its own
            if (row.op == OpStartBusy)
            begin
                for (int i = 0; i < int'(IgnoredLen) + 4; i++)
                begin
                    advanceCycle();
                    checkBit("done_o", done_o, 1'b0);
                    checkBit("busy_o", busy_o, 1'b0);
                end
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial
    begin
        rst_i        = 1'b1;
        testEn_i     = 1'b0;
        weightWe_i   = 1'b0;
        weightAddr_i = '0;
        weightData_i = '0;
        pixelWe_i    = 1'b0;
        pixelAddr_i  = '0;
        pixelData_i  = '0;
        start_i      = 1'b0;
        len_i        = '0;
        seed         = 38;
        fillTable();
        timeoutLimit = ResetCycles + stimRows.size() * CyclesPerRow;
        repeat (ResetCycles) @(posedge clk);
        #2;
        rst_i = 1'b0;
        // Quiet after reset
        for (int i = 0; i < 4; i++)
        begin
            checkBit("busy_o", busy_o, 1'b0);
            checkBit("done_o", done_o, 1'b0);
            checkAcc("result_o", result_o, accT'(0));
            advanceCycle();
        end
        foreach (stimRows[i])
        begin
            case (stimRows[i].op)
                OpWriteWeight, OpWritePixel: writeWord(stimRows[i]);
                default: runDot(stimRows[i]);
            endcase
        end
        passReported = 1'b1;
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: scmDot.f
design/scmDotPkg.sv
design/clockGateCell.sv
design/registerFile1r1w.sv
design/dotSequencer.sv
design/macAccumulator.sv
design/scmDotTop.sv
verif/scmDot_assertions.sv
verif/scmDotTb.sv

// File: run.sh
#!/bin/sh
# Compile the scmDot testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module scmDotTb \
    -f scmDot.f \
    --Mdir obj_dir \
    -o scmDotSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/scmDotSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
